//--- hw/l2_cache_pkg.sv
// Geometry and shared types of the L2 cache
// Imported with a wildcard by every cache module and by the testbench
`default_nettype none

package l2_cache_pkg;

   // Byte address and data word
   localparam int ADDR_W = 25;
   localparam int DATA_W = 32;

   // 4 ways, 16 sets, 32-byte lines
   localparam int WAYS_LG2 = 2;
   localparam int SETS_LG2 = 4;
   localparam int LINE_LG2 = 5;
   localparam int NWAYS = 1 << WAYS_LG2;
   localparam int NSETS = 1 << SETS_LG2;
   localparam int TAG_W = ADDR_W - SETS_LG2 - LINE_LG2;

   // Half-word beats per line burst
   localparam int BEATS = 16;

   // Word address of the line RAM: way, set, word in line
   localparam int RAM_AW = WAYS_LG2 + SETS_LG2 + LINE_LG2 - 2;

   typedef logic [DATA_W-1:0] l2_data_t;
   typedef logic [DATA_W/8-1:0] l2_mask_t;
   typedef logic [DATA_W/2-1:0] sdr_half_t;

   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [SETS_LG2-1:0] set;
      logic [LINE_LG2-3:0] word;
      logic [1:0]          bsel;
   } l2_addr_f_t;

   // One byte address, seen raw or split into fields
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      l2_addr_f_t        f;
   } l2_addr_u;

   // All-zero mask means read
   typedef struct packed {
      l2_addr_u addr;
      l2_data_t wdata;
      l2_mask_t wmask;
   } l2_cmd_t;

   // Burst request to the SDRAM side, line address is tag and set
   typedef struct packed {
      logic                       rd;
      logic                       we;
      logic [ADDR_W-LINE_LG2-1:0] line;
   } nl_req_t;

endpackage

`default_nettype wire

//--- hw/l2_cmd_hold.sv
// Command-side buffer of the L2 cache
// Holds one accepted command and bypasses a new one while the last response is taken
`timescale 1ns/1ps
`default_nettype none

module l2_cmd_hold
   import l2_cache_pkg::*;
(
   input  wire           clk,
   input  wire           rst_n,
   input  wire           cmd_valid,
   input  wire l2_cmd_t  cmd,
   input  wire           rsp_ready,
   input  wire           rsp_ok,
   output logic          cmd_ready,
   output logic          rsp_valid,
   output l2_cmd_t       eff_cmd,
   output logic          mreq
);
   logic    pending;
   logic    push;
   logic    pop;
   logic    use_held;
   l2_cmd_t held;

   assign push = cmd_valid & cmd_ready;
   assign pop = rsp_valid & rsp_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending <= 1'b0;
      end else if (push | pop) begin
         pending <= push | ~pop;
      end
   end

   // Capture whatever is offered whenever a new command may enter
   always_ff @(posedge clk) begin
      if (cmd_ready) begin
         held <= cmd;
      end
   end

   // Bypass when the slot is free or is being emptied this cycle
   assign cmd_ready = ~pending | pop;
   assign use_held = pending & ~pop;
   assign eff_cmd = use_held ? held : cmd;
   assign mreq = use_held | push;
   assign rsp_valid = pending & rsp_ok;

endmodule

`default_nettype wire

//--- hw/l2_tag_store.sv
// Tag, valid, dirty and LRU rank arrays of the 4-way L2 cache
// Looks up hit and victim for the current set and updates on hit or fill
`timescale 1ns/1ps
`default_nettype none

module l2_tag_store
   import l2_cache_pkg::*;
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire l2_addr_u        addr,
   input  wire                  flush_active,
   input  wire [WAYS_LG2-1:0]   flush_way,
   input  wire [SETS_LG2-1:0]   flush_set,
   input  wire                  update,
   input  wire                  fill,
   input  wire                  write,
   output logic                 hit,
   output logic [WAYS_LG2-1:0]  hit_way,
   output logic [WAYS_LG2-1:0]  victim_way,
   output logic                 victim_dirty,
   output logic [TAG_W-1:0]     victim_tag
);
   logic                valid [NWAYS][NSETS];
   logic                dirty [NWAYS][NSETS];
   logic [WAYS_LG2-1:0] rank  [NWAYS][NSETS];
   logic [TAG_W-1:0]    tags  [NWAYS][NSETS];
   logic [SETS_LG2-1:0] idx;

   assign idx = flush_active ? flush_set : addr.f.set;

   // Never hits during a flush walk
   always_comb begin
      hit = 1'b0;
      hit_way = '0;
      for (int w = 0; w < NWAYS; w++) begin
         if (!flush_active && valid[w][idx] && tags[w][idx] == addr.f.tag) begin
            hit = 1'b1;
            hit_way = WAYS_LG2'(w);
         end
      end
   end

   // Rank zero is least recently used
   always_comb begin
      victim_way = flush_way;
      if (!flush_active) begin
         for (int w = 0; w < NWAYS; w++) begin
            if (rank[w][idx] == '0) begin
               victim_way = WAYS_LG2'(w);
            end
         end
      end
   end

   assign victim_dirty = dirty[victim_way][idx];
   assign victim_tag = tags[victim_way][idx];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int w = 0; w < NWAYS; w++) begin
            for (int s = 0; s < NSETS; s++) begin
               valid[w][s] <= 1'b0;
               dirty[w][s] <= 1'b0;
               rank[w][s] <= WAYS_LG2'(w);
               tags[w][s] <= '0;
            end
         end
      end else if (update) begin
         // Hit way to the top, ranks above its old one step down
         for (int w = 0; w < NWAYS; w++) begin
            if (WAYS_LG2'(w) == hit_way) begin
               rank[w][idx] <= '1;
               if (write) begin
                  dirty[w][idx] <= 1'b1;
               end
            end else if (rank[w][idx] > rank[hit_way][idx]) begin
               rank[w][idx] <= rank[w][idx] - 1'b1;
            end
         end
      end else if (fill) begin
         // A walk only cleans the entry, a miss also retags it
         dirty[victim_way][idx] <= 1'b0;
         if (!flush_active) begin
            valid[victim_way][idx] <= 1'b1;
            tags[victim_way][idx] <= addr.f.tag;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/l2_cache_ctrl.sv
// Miss, write-back and flush controller of the L2 cache
// Serves hits in idle, runs write-back and refill bursts, walks all entries on flush
`timescale 1ns/1ps
`default_nettype none

module l2_cache_ctrl
   import l2_cache_pkg::*;
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  mreq,
   input  wire l2_cmd_t         eff_cmd,
   input  wire                  flush,
   input  wire                  hit,
   input  wire [WAYS_LG2-1:0]   hit_way,
   input  wire [WAYS_LG2-1:0]   victim_way,
   input  wire                  victim_dirty,
   input  wire [TAG_W-1:0]      victim_tag,
   input  wire                  burst_done,
   output logic                 rsp_ok,
   output logic                 ram_en_hit,
   output nl_req_t              nl_req,
   output logic [WAYS_LG2-1:0]  line_way,
   output logic [SETS_LG2-1:0]  line_set,
   output logic                 update,
   output logic                 fill,
   output logic                 write,
   output logic                 flush_active,
   output logic [WAYS_LG2-1:0]  flush_way,
   output logic [SETS_LG2-1:0]  flush_set
);
   typedef enum logic [1:0] {S_IDLE, S_WR_PEND, S_RAW, S_RD_PEND} state_t;

   state_t                       state;
   logic                         flush_req;
   logic [WAYS_LG2+SETS_LG2-1:0] fcnt;
   logic [WAYS_LG2-1:0]          burst_way;
   logic [SETS_LG2-1:0]          burst_set;
   logic [SETS_LG2-1:0]          cur_set;
   logic                         idle;
   logic                         hold_rsp;
   logic                         walk_start;
   logic                         serve;
   logic                         step;

   assign idle = state == S_IDLE;
   assign {flush_way, flush_set} = fcnt;
   assign cur_set = flush_active ? flush_set : eff_cmd.addr.f.set;

   // A response already on the port is not withdrawn by a pending flush
   assign hold_rsp = mreq & rsp_ok;
   assign walk_start = idle & flush_req & ~flush_active & ~hold_rsp;
   assign serve = idle & mreq & hit & ~walk_start;
   assign fill = idle & ~walk_start & (flush_active ? victim_dirty : mreq & ~hit);
   assign step = flush_active & ((idle & ~victim_dirty) | (state == S_RAW));

   assign ram_en_hit = serve;
   assign update = serve;
   assign write = |eff_cmd.wmask;
   assign line_way = idle ? hit_way : burst_way;
   assign line_set = idle ? eff_cmd.addr.f.set : burst_set;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flush_req <= 1'b0;
         flush_active <= 1'b0;
         fcnt <= '0;
      end else begin
         flush_req <= (flush_req & ~walk_start) | flush;
         if (walk_start) begin
            flush_active <= 1'b1;
         end else if (step) begin
            fcnt <= fcnt + 1'b1;
            // Last way of the last set ends the walk
            if (&fcnt) begin
               flush_active <= 1'b0;
            end
         end
      end
   end

   // Entry under burst, fixed until the next fill
   always_ff @(posedge clk) begin
      if (fill) begin
         burst_way <= victim_way;
         burst_set <= cur_set;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= S_IDLE;
         rsp_ok <= 1'b0;
         nl_req <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               rsp_ok <= serve;
               if (fill) begin
                  nl_req.we <= victim_dirty;
                  nl_req.rd <= ~victim_dirty;
                  nl_req.line <= victim_dirty ? {victim_tag, cur_set}
                                              : eff_cmd.addr.raw[ADDR_W-1:LINE_LG2];
                  state <= victim_dirty ? S_WR_PEND : S_RD_PEND;
               end
            end
            S_WR_PEND: begin
               if (burst_done) begin
                  nl_req.we <= 1'b0;
                  state <= S_RAW;
               end
            end
            // Write request drops here before any refill is raised
            S_RAW: begin
               if (flush_active) begin
                  state <= S_IDLE;
               end else begin
                  nl_req.rd <= 1'b1;
                  nl_req.line <= eff_cmd.addr.raw[ADDR_W-1:LINE_LG2];
                  state <= S_RD_PEND;
               end
            end
            S_RD_PEND: begin
               if (burst_done) begin
                  nl_req.rd <= 1'b0;
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/l2_line_ram.sv
// Data RAM of the L2 cache, one word port for hits and one burst port
// The burst port writes and reads half-words by beat parity
`timescale 1ns/1ps
`default_nettype none

module l2_line_ram
   import l2_cache_pkg::*;
(
   input  wire                           clk,
   input  wire                           hit_en,
   input  wire [RAM_AW-1:0]              hit_addr,
   input  wire l2_mask_t                 hit_wmask,
   input  wire l2_data_t                 hit_wdata,
   input  wire                           beat_en,
   input  wire                           beat_we,
   input  wire [WAYS_LG2+SETS_LG2-1:0]   beat_addr,
   input  wire [$clog2(BEATS)-1:0]       beat_idx,
   input  wire sdr_half_t                beat_wdata,
   output l2_data_t                      hit_rdata,
   output l2_data_t                      beat_rdata
);
   l2_data_t          mem [1 << RAM_AW];
   logic [RAM_AW-1:0] word_addr;
   l2_mask_t          beat_mask;
   l2_data_t          beat_word;

   // Two beats per word, even beat in the low half
   assign word_addr = {beat_addr, beat_idx[$clog2(BEATS)-1:1]};
   assign beat_mask = beat_idx[0] ? 4'b1100 : 4'b0011;
   assign beat_word = {beat_wdata, beat_wdata};

   always_ff @(posedge clk) begin
      if (hit_en) begin
         for (int b = 0; b < DATA_W/8; b++) begin
            if (hit_wmask[b]) begin
               mem[hit_addr][8*b +: 8] <= hit_wdata[8*b +: 8];
            end
         end
         hit_rdata <= mem[hit_addr];
      end
      if (beat_en) begin
         for (int b = 0; b < DATA_W/8; b++) begin
            if (beat_we && beat_mask[b]) begin
               mem[word_addr][8*b +: 8] <= beat_word[8*b +: 8];
            end
         end
         beat_rdata <= mem[word_addr];
      end
   end

endmodule

`default_nettype wire

//--- hw/l2_sdram_port.sv
// SDRAM side of the L2 cache, request levels, beat counter and write data
// Write requests win over read requests
`timescale 1ns/1ps
`default_nettype none

module l2_sdram_port
   import l2_cache_pkg::*;
(
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire nl_req_t              nl_req,
   input  wire l2_data_t             beat_rdata,
   input  wire                       sdr_r_vld,
   input  wire                       sdr_w_rdy,
   input  wire sdr_half_t            sdr_rdata,
   output logic                      sdr_rd_req,
   output logic                      sdr_we_req,
   output logic [ADDR_W-2:0]         sdr_addr,
   output sdr_half_t                 sdr_wdata,
   output logic                      beat_en,
   output logic                      beat_we,
   output logic [$clog2(BEATS)-1:0]  beat_idx,
   output sdr_half_t                 beat_wdata,
   output logic                      burst_done
);
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sdr_we_req <= 1'b0;
         sdr_rd_req <= 1'b0;
      end else begin
         sdr_we_req <= nl_req.we;
         sdr_rd_req <= nl_req.rd & ~nl_req.we;
      end
   end

   // Half-word address of the line start
   always_ff @(posedge clk) begin
      sdr_addr <= {nl_req.line, {(LINE_LG2-1){1'b0}}};
   end

   assign beat_we = sdr_r_vld & sdr_rd_req;
   assign beat_en = beat_we | (sdr_w_rdy & sdr_we_req);
   assign beat_wdata = sdr_rdata;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_idx <= '0;
      end else if (beat_en) begin
         beat_idx <= beat_idx + 1'b1;
      end
   end

   // Counter wraps on the last beat of the burst
   assign burst_done = beat_en & (&beat_idx);

   // RAM word arrives one beat later, so the counter parity is already flipped
   always_ff @(posedge clk) begin
      sdr_wdata <= beat_idx[0] ? beat_rdata[15:0] : beat_rdata[31:16];
   end

endmodule

`default_nettype wire

//--- hw/l2_cache_top.sv
// L2 cache top level, command port in front and 16-bit burst SDRAM behind
// Connects the command buffer, tag store, controller, line RAM and SDRAM port
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top
   import l2_cache_pkg::*;
(
   input  wire                clk,
   input  wire                rst_n,
   input  wire                cmd_valid,
   output logic               cmd_ready,
   input  wire l2_cmd_t       cmd,
   output logic               rsp_valid,
   input  wire                rsp_ready,
   output l2_data_t           rsp_data,
   input  wire                flush,
   output logic               sdr_rd_req,
   output logic               sdr_we_req,
   output logic [ADDR_W-2:0]  sdr_addr,
   input  wire sdr_half_t     sdr_rdata,
   input  wire                sdr_r_vld,
   output sdr_half_t          sdr_wdata,
   input  wire                sdr_w_rdy
);
   l2_cmd_t                    eff_cmd;
   logic                       mreq;
   logic                       rsp_ok;
   logic                       ram_en_hit;
   nl_req_t                    nl_req;

   logic                       hit;
   logic [WAYS_LG2-1:0]        hit_way;
   logic [WAYS_LG2-1:0]        victim_way;
   logic                       victim_dirty;
   logic [TAG_W-1:0]           victim_tag;
   logic                       update;
   logic                       fill;
   logic                       write;
   logic                       flush_active;
   logic [WAYS_LG2-1:0]        flush_way;
   logic [SETS_LG2-1:0]        flush_set;

   logic [WAYS_LG2-1:0]        line_way;
   logic [SETS_LG2-1:0]        line_set;
   l2_data_t                   beat_rdata;
   logic                       beat_en;
   logic                       beat_we;
   logic [$clog2(BEATS)-1:0]   beat_idx;
   sdr_half_t                  beat_wdata;
   logic                       burst_done;

   l2_cmd_hold hold0 (
      .clk, .rst_n, .cmd_valid, .cmd, .rsp_ready, .rsp_ok,
      .cmd_ready, .rsp_valid, .eff_cmd, .mreq
   );

   l2_tag_store tags0 (
      .clk, .rst_n, .addr(eff_cmd.addr), .flush_active, .flush_way, .flush_set,
      .update, .fill, .write, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
   );

   l2_cache_ctrl ctrl0 (
      .clk, .rst_n, .mreq, .eff_cmd, .flush, .hit, .hit_way, .victim_way,
      .victim_dirty, .victim_tag, .burst_done, .rsp_ok, .ram_en_hit, .nl_req,
      .line_way, .line_set, .update, .fill, .write, .flush_active, .flush_way, .flush_set
   );

   // Hit port and burst port share the way and set chosen by the controller
   l2_line_ram ram0 (
      .clk,
      .hit_en    (ram_en_hit),
      .hit_addr  ({line_way, line_set, eff_cmd.addr.f.word}),
      .hit_wmask (eff_cmd.wmask),
      .hit_wdata (eff_cmd.wdata),
      .beat_en, .beat_we,
      .beat_addr ({line_way, line_set}),
      .beat_idx, .beat_wdata,
      .hit_rdata (rsp_data),
      .beat_rdata
   );

   l2_sdram_port port0 (
      .clk, .rst_n, .nl_req, .beat_rdata, .sdr_r_vld, .sdr_w_rdy, .sdr_rdata,
      .sdr_rd_req, .sdr_we_req, .sdr_addr, .sdr_wdata, .beat_en, .beat_we,
      .beat_idx, .beat_wdata, .burst_done
   );

endmodule

`default_nettype wire

//--- sim/sdram_model.sv
// Behavioral 16-bit burst SDRAM for the L2 cache testbench
// Serves level requests with per-beat strobes and counts the bursts it runs
`timescale 1ns/1ps
`default_nettype none

module sdram_model
   import l2_cache_pkg::*;
(
   input  wire                clk,
   input  wire                rst_n,
   input  wire                rd_req,
   input  wire                we_req,
   input  wire [ADDR_W-2:0]   addr,
   input  wire sdr_half_t     wdata,
   output sdr_half_t          rdata,
   output logic               r_vld,
   output logic               w_rdy
);
   localparam int MEM_LG2 = 12;

   sdr_half_t          mem [1 << MEM_LG2];
   logic [4:0]         cnt;
   logic [1:0]         wpipe;
   logic [MEM_LG2-1:0] base;
   logic [MEM_LG2-1:0] wa0;
   logic [MEM_LG2-1:0] wa1;
   logic [MEM_LG2-1:0] wa2;
   int                 rd_bursts;
   int                 wr_bursts;

   assign base = addr[MEM_LG2-1:0];

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
         r_vld <= 1'b0;
         w_rdy <= 1'b0;
         wpipe <= '0;
         rd_bursts <= 0;
         wr_bursts <= 0;
      end else begin
         r_vld <= 1'b0;
         w_rdy <= 1'b0;
         // Write data shows up two cycles after its strobe
         wpipe <= {wpipe[0], w_rdy};
         wa1 <= wa0;
         wa2 <= wa1;
         if (wpipe[1]) begin
            mem[wa2] <= wdata;
         end
         if (!rd_req && !we_req) begin
            cnt <= '0;
         end else if (cnt < BEATS) begin
            if (cnt == 0) begin
               if (we_req) wr_bursts <= wr_bursts + 1;
               else rd_bursts <= rd_bursts + 1;
            end
            if (we_req) begin
               w_rdy <= 1'b1;
               wa0 <= base + MEM_LG2'(cnt);
            end else begin
               r_vld <= 1'b1;
               rdata <= mem[base + MEM_LG2'(cnt)];
            end
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- sim/l2_cache_tb.sv
// Directed testbench of the L2 cache against a behavioral SDRAM
// Expected data comes from a shadow copy of memory kept by the tests
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb
   import l2_cache_pkg::*;
();
   localparam int TIMEOUT = 2000;
   localparam int SHADOW_WORDS = 2048;

   logic               clk;
   logic               rst_n;
   logic               cmd_valid;
   logic               cmd_ready;
   l2_cmd_t            cmd;
   logic               rsp_valid;
   logic               rsp_ready;
   l2_data_t           rsp_data;
   logic               flush;
   logic               sdr_rd_req;
   logic               sdr_we_req;
   logic [ADDR_W-2:0]  sdr_addr;
   sdr_half_t          sdr_rdata;
   logic               sdr_r_vld;
   sdr_half_t          sdr_wdata;
   logic               sdr_w_rdy;

   integer             seed;
   l2_data_t           shadow [SHADOW_WORDS];
   int                 value_errors;
   int                 timeout_errors;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   l2_cache_top dut0 (
      .clk, .rst_n, .cmd_valid, .cmd_ready, .cmd, .rsp_valid, .rsp_ready, .rsp_data,
      .flush, .sdr_rd_req, .sdr_we_req, .sdr_addr, .sdr_rdata, .sdr_r_vld,
      .sdr_wdata, .sdr_w_rdy
   );

   sdram_model sdram0 (
      .clk, .rst_n, .rd_req(sdr_rd_req), .we_req(sdr_we_req), .addr(sdr_addr),
      .wdata(sdr_wdata), .rdata(sdr_rdata), .r_vld(sdr_r_vld), .w_rdy(sdr_w_rdy)
   );

   function automatic l2_addr_u line_addr(int tag, int set, int word);
      l2_addr_u a;
      a.raw = '0;
      a.f.tag = TAG_W'(tag);
      a.f.set = SETS_LG2'(set);
      a.f.word = (LINE_LG2-2)'(word);
      return a;
   endfunction

   function automatic int word_index(l2_addr_u a);
      return int'(a.raw[12:2]);
   endfunction

   // Word as the SDRAM holds it with the low half at the even address
   function automatic l2_data_t model_word(int widx);
      return {sdram0.mem[2*widx+1], sdram0.mem[2*widx]};
   endfunction

   task automatic check_data(input l2_data_t got, input l2_data_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("FAILED @%0t: %s got %0d expected %0d", $time, what, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
         value_errors++;
      end
   endtask

   task automatic note_timeout(input string what);
      $display("Timeout at %0t while waiting for %s", $time, what);
      timeout_errors++;
   endtask

   task automatic send(input l2_addr_u a, input l2_data_t wd, input l2_mask_t m);
      l2_cmd_t c;
      int      n;
      c.addr = a;
      c.wdata = wd;
      c.wmask = m;
      @(posedge clk);
      cmd_valid <= 1'b1;
      cmd <= c;
      n = 0;
      @(negedge clk);
      while (!cmd_ready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (n >= TIMEOUT) note_timeout("command acceptance");
      @(posedge clk);
      cmd_valid <= 1'b0;
   endtask

   task automatic wait_rsp(output l2_data_t d);
      int n;
      n = 0;
      @(negedge clk);
      while (!rsp_valid && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (n >= TIMEOUT) note_timeout("a response");
      d = rsp_data;
   endtask

   // Writes are merged into the shadow by byte mask
   task automatic issue(input l2_addr_u a, input l2_data_t wd, input l2_mask_t m,
                        output l2_data_t d);
      int i;
      i = word_index(a);
      send(a, wd, m);
      wait_rsp(d);
      for (int b = 0; b < DATA_W/8; b++) begin
         if (m[b]) shadow[i][8*b +: 8] = wd[8*b +: 8];
      end
   endtask

   task automatic read_check(input l2_addr_u a, input string what);
      l2_data_t d;
      issue(a, '0, '0, d);
      check_data(d, shadow[word_index(a)], what);
   endtask

   task automatic flush_pulse();
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
   endtask

   task automatic reset_values();
      @(negedge clk);
      check_bit(cmd_ready, 1'b1, "cmd_ready after reset");
      check_bit(rsp_valid, 1'b0, "rsp_valid after reset");
      check_bit(sdr_rd_req, 1'b0, "sdr_rd_req after reset");
      check_bit(sdr_we_req, 1'b0, "sdr_we_req after reset");
   endtask

   task automatic read_miss_refill();
      int r0;
      r0 = sdram0.rd_bursts;
      read_check(line_addr(3, 1, 2), "read miss data");
      check_count(sdram0.rd_bursts - r0, 1, "read bursts on miss");
      r0 = sdram0.rd_bursts;
      read_check(line_addr(3, 1, 5), "read hit data");
      check_count(sdram0.rd_bursts - r0, 0, "read bursts on hit");
   endtask

   task automatic write_hit_merge();
      int       r0;
      int       w0;
      l2_data_t d;
      r0 = sdram0.rd_bursts;
      w0 = sdram0.wr_bursts;
      issue(line_addr(3, 1, 5), 32'ha5c3_7e19, 4'b0110, d);
      read_check(line_addr(3, 1, 5), "merged bytes");
      check_count(sdram0.rd_bursts - r0, 0, "read bursts on write hit");
      check_count(sdram0.wr_bursts - w0, 0, "write bursts on write hit");
   endtask

   task automatic lru_eviction();
      int       r0;
      int       w0;
      l2_data_t d;
      read_check(line_addr(2, 2, 1), "fill tag 2");
      issue(line_addr(1, 2, 0), 32'h1234_5678, 4'hf, d);
      read_check(line_addr(3, 2, 1), "fill tag 3");
      read_check(line_addr(4, 2, 1), "fill tag 4");
      // Touching the first filled tag 2 leaves the dirty tag 1 as the oldest
      read_check(line_addr(2, 2, 3), "touch tag 2");
      r0 = sdram0.rd_bursts;
      w0 = sdram0.wr_bursts;
      read_check(line_addr(5, 2, 6), "fill tag 5");
      check_count(sdram0.wr_bursts - w0, 1, "write-back bursts on eviction");
      check_count(sdram0.rd_bursts - r0, 1, "refill bursts on eviction");
      for (int w = 0; w < 8; w++) begin
         check_data(model_word(word_index(line_addr(1, 2, w))),
                    shadow[word_index(line_addr(1, 2, w))], "written-back word");
      end
      r0 = sdram0.rd_bursts;
      read_check(line_addr(2, 2, 7), "recent line after eviction");
      check_count(sdram0.rd_bursts - r0, 0, "read bursts on recent line");
   endtask

   task automatic flush_writeback();
      int       w0;
      l2_data_t d;
      issue(line_addr(6, 3, 1), 32'h0bad_cafe, 4'b1001, d);
      flush_pulse();
      read_check(line_addr(6, 3, 1), "read after flush");
      for (int i = 0; i < SHADOW_WORDS; i++) begin
         check_data(model_word(i), shadow[i], "memory after flush");
      end
      w0 = sdram0.wr_bursts;
      flush_pulse();
      read_check(line_addr(6, 3, 2), "read after second flush");
      check_count(sdram0.wr_bursts - w0, 0, "write bursts of second flush");
   endtask

   task automatic rsp_backpressure();
      l2_data_t first;
      @(posedge clk);
      rsp_ready <= 1'b0;
      send(line_addr(2, 2, 4), '0, '0);
      wait_rsp(first);
      check_data(first, shadow[word_index(line_addr(2, 2, 4))], "held response data");
      repeat (6) begin
         @(negedge clk);
         check_bit(rsp_valid, 1'b1, "rsp_valid while stalled");
         check_data(rsp_data, shadow[word_index(line_addr(2, 2, 4))],
                    "rsp_data while stalled");
         check_bit(cmd_ready, 1'b0, "cmd_ready while stalled");
      end
      @(posedge clk);
      rsp_ready <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_bit(rsp_valid, 1'b0, "rsp_valid after release");
      check_bit(cmd_ready, 1'b1, "cmd_ready after release");
   endtask

   initial begin
      l2_data_t w;
      rst_n = 1'b0;
      cmd_valid = 1'b0;
      cmd = '0;
      rsp_ready = 1'b1;
      flush = 1'b0;
      value_errors = 0;
      timeout_errors = 0;
      seed = 32'hf05f9a53;
      for (int i = 0; i < SHADOW_WORDS; i++) begin
         w = $random(seed);
         shadow[i] = w;
         sdram0.mem[2*i] = w[15:0];
         sdram0.mem[2*i+1] = w[31:16];
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      reset_values();
      read_miss_refill();
      write_hit_merge();
      lru_eviction();
      flush_writeback();
      rsp_backpressure();

      $display("Errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
hw/l2_cache_pkg.sv
hw/l2_cmd_hold.sv
hw/l2_tag_store.sv
hw/l2_cache_ctrl.sv
hw/l2_line_ram.sv
hw/l2_sdram_port.sv
hw/l2_cache_top.sv
sim/sdram_model.sv
sim/l2_cache_tb.sv

//--- Makefile
# Verilator build and run of the L2 cache testbench

VERILATOR ?= verilator
TOP       ?= l2_cache_tb
RTL_TOP   ?= l2_cache_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS = hw/l2_cache_pkg.sv hw/l2_cmd_hold.sv hw/l2_tag_store.sv hw/l2_cache_ctrl.sv \
           hw/l2_line_ram.sv hw/l2_sdram_port.sv hw/l2_cache_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
